//--- verilog/dataPathPkg.sv
`default_nettype none

package dataPathPkg;

	// Bus and register word
	typedef logic [31:0] wordT;

	// General-register index, R0 to R15
	typedef logic [3:0] regIdxT;

	// ALU operation codes as driven on opSelect
	typedef enum logic [5:0] {
		opAdd,
		opSub,
		opAnd,
		opOr,
		opShr,
		opShra,
		opShl,
		opRor,
		opRol,
		opMul,
		opDiv,
		opNeg,
		opNot
	} aluOpT;

	// Bus source enables, highest priority first
	typedef struct packed {
		logic tb;
		logic rf;
		logic pc;
		logic ir;
		logic ry;
		logic rz;
		logic mar;
		logic hi;
		logic lo;
		logic mdr;
		logic imm;
	} busSelT;

	// 64-bit ALU result, also the layout of RZ
	typedef struct packed {
		wordT hi;
		wordT lo;
	} aluResultT;

endpackage

`default_nettype wire

//--- verilog/regFile.sv
`timescale 1ns/100ps
`default_nettype none

module regFile (
	input wire clock,
	input wire rst,
	input wire writeEn,
	input wire dataPathPkg::regIdxT index,
	input wire readZero,
	input wire dataPathPkg::wordT writeData,
	output dataPathPkg::wordT readData
);

	dataPathPkg::wordT regs [16];

	always_ff @(posedge clock) begin
		if (rst) begin
			regs <= '{default: '0};
		end else if (writeEn) begin
			regs[index] <= writeData;
		end
	end

	// Base-address mode treats R0 as a constant zero
	always_comb begin
		if (readZero)
			readData = '0;
		else
			readData = regs[index];
	end

endmodule

`default_nettype wire

//--- verilog/regSelect.sv
`timescale 1ns/100ps
`default_nettype none

module regSelect (
	input wire dataPathPkg::wordT ir,
	input wire gra,
	input wire grb,
	input wire grc,
	input wire rIn,
	input wire rOut,
	input wire baOut,
	output dataPathPkg::regIdxT index,
	output logic rfIn,
	output logic rfOut,
	output logic readZero,
	output dataPathPkg::wordT imm
);

	dataPathPkg::regIdxT ra, rb, rc;

	// Instruction register fields
	assign ra = ir[26:23];
	assign rb = ir[22:19];
	assign rc = ir[18:15];

	// Field select in gra, grb, grc order
	always_comb begin
		if (gra)
			index = ra;
		else if (grb)
			index = rb;
		else if (grc)
			index = rc;
		else
			index = '0;
	end

	assign rfIn = rIn;
	assign rfOut = rOut | baOut;

	// R0 reads as zero only for base-address use
	assign readZero = baOut && (index == 4'd0);

	// 19-bit immediate, sign-extended
	assign imm = {{13{ir[18]}}, ir[18:0]};

endmodule

`default_nettype wire

//--- verilog/busMux.sv
`timescale 1ns/100ps
`default_nettype none

module busMux (
	input wire dataPathPkg::busSelT sel,
	input wire dataPathPkg::wordT tb,
	input wire dataPathPkg::wordT rf,
	input wire dataPathPkg::wordT pc,
	input wire dataPathPkg::wordT ir,
	input wire dataPathPkg::wordT ry,
	input wire dataPathPkg::wordT rz,
	input wire dataPathPkg::wordT mar,
	input wire dataPathPkg::wordT hi,
	input wire dataPathPkg::wordT lo,
	input wire dataPathPkg::wordT mdr,
	input wire dataPathPkg::wordT imm,
	output dataPathPkg::wordT bus
);

	// Testbench drive outranks every device
	always_comb begin
		if (sel.tb)
			bus = tb;
		else if (sel.rf)
			bus = rf;
		else if (sel.pc)
			bus = pc;
		else if (sel.ir)
			bus = ir;
		else if (sel.ry)
			bus = ry;
		else if (sel.rz)
			bus = rz;
		else if (sel.mar)
			bus = mar;
		else if (sel.hi)
			bus = hi;
		else if (sel.lo)
			bus = lo;
		else if (sel.mdr)
			bus = mdr;
		else if (sel.imm)
			bus = imm;
		else
			bus = '0;
	end

endmodule

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
	input wire clock,
	input wire rst,
	input wire dataPathPkg::aluOpT op,
	input wire dataPathPkg::wordT a,
	input wire dataPathPkg::wordT b,
	input wire start,
	output dataPathPkg::aluResultT result,
	output logic finished
);

	typedef enum logic [1:0] {
		aluIdle,
		aluMul,
		aluDiv
	} aluStateT;

	aluStateT state;
	logic [4:0] stepCnt;
	logic lastStep;

	// Working registers shared by multiply and divide
	dataPathPkg::wordT workHi, workLo, operand;

	dataPathPkg::wordT single;
	logic [4:0] shamt;
	logic [63:0] rotR, rotL;

	logic [32:0] mulSum;
	dataPathPkg::wordT mulHi, mulLo;
	logic [32:0] divShift, divDiff;
	logic divOk;
	dataPathPkg::wordT divHi, divLo;

	assign shamt = b[4:0];
	assign rotR = {a, a} >> shamt;
	assign rotL = {a, a} << shamt;

	// One-cycle ops; unary ones work on B
	always_comb begin
		case (op)
			dataPathPkg::opAdd: single = a + b;
			dataPathPkg::opSub: single = a - b;
			dataPathPkg::opAnd: single = a & b;
			dataPathPkg::opOr: single = a | b;
			dataPathPkg::opShr: single = a >> shamt;
			dataPathPkg::opShra: single = $signed(a) >>> shamt;
			dataPathPkg::opShl: single = a << shamt;
			dataPathPkg::opRor: single = rotR[31:0];
			dataPathPkg::opRol: single = rotL[63:32];
			dataPathPkg::opNeg: single = -b;
			dataPathPkg::opNot: single = ~b;
			default: single = '0;
		endcase
	end

	// Shift-add step, product builds in workHi:workLo
	assign mulSum = {1'b0, workHi} + (workLo[0] ? {1'b0, operand} : 33'd0);
	assign mulHi = mulSum[32:1];
	assign mulLo = {mulSum[0], workLo[31:1]};

	// Restoring step, remainder in workHi and quotient shifting into workLo
	// A zero divisor always subtracts, leaving all ones and the dividend
	assign divShift = {workHi, workLo[31]};
	assign divDiff = divShift - {1'b0, operand};
	assign divOk = ~divDiff[32];
	assign divHi = divOk ? divDiff[31:0] : divShift[31:0];
	assign divLo = {workLo[30:0], divOk};

	assign lastStep = (stepCnt == 5'd31);

	// Control
	always_ff @(posedge clock) begin
		if (rst) begin
			state <= aluIdle;
			stepCnt <= '0;
			finished <= 1'b0;
		end else begin
			finished <= 1'b0;
			case (state)
				aluIdle: begin
					stepCnt <= '0;
					if (start) begin
						if (op == dataPathPkg::opMul)
							state <= aluMul;
						else if (op == dataPathPkg::opDiv)
							state <= aluDiv;
						else
							finished <= 1'b1;
					end
				end
				default: begin
					stepCnt <= stepCnt + 5'd1;
					if (lastStep) begin
						state <= aluIdle;
						finished <= 1'b1;
					end
				end
			endcase
		end
	end

	// Operands, steps and result
	always_ff @(posedge clock) begin
		case (state)
			aluIdle: begin
				if (start) begin
					if (op == dataPathPkg::opMul) begin
						workHi <= '0;
						workLo <= b;
						operand <= a;
					end else if (op == dataPathPkg::opDiv) begin
						workHi <= '0;
						workLo <= a;
						operand <= b;
					end else begin
						result <= '{hi: '0, lo: single};
					end
				end
			end
			aluMul: begin
				workHi <= mulHi;
				workLo <= mulLo;
				if (lastStep)
					result <= '{hi: mulHi, lo: mulLo};
			end
			default: begin
				workHi <= divHi;
				workLo <= divLo;
				if (lastStep)
					result <= '{hi: divHi, lo: divLo};
			end
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/memSys.sv
`timescale 1ns/100ps
`default_nettype none

module memSys #(
	parameter int memDepth = 512,
	parameter int memLatency = 3
) (
	input wire clock,
	input wire rst,
	input wire read,
	input wire write,
	input wire marIn,
	input wire mdrIn,
	input wire dataPathPkg::wordT bus,
	output dataPathPkg::wordT mar,
	output dataPathPkg::wordT mdr,
	output logic memFinished
);

	localparam int addrW = $clog2(memDepth);
	localparam int cntW = $clog2(memLatency + 1);

	dataPathPkg::wordT mem [memDepth];

	logic busy, isWrite;
	logic [addrW-1:0] addrReg, curAddr;
	logic [cntW-1:0] count, stepCount;
	logic startAcc, curWrite, done, readActive;

	// New strobes only count when idle
	assign startAcc = (read | write) & ~busy;
	assign curWrite = busy ? isWrite : write;
	assign curAddr = busy ? addrReg : addrW'(mar % memDepth);

	// Edges spent on this access, including the current one
	assign stepCount = busy ? count + cntW'(1) : cntW'(1);
	assign done = (busy | startAcc) && (stepCount == cntW'(memLatency));
	assign readActive = (busy | startAcc) & ~curWrite;

	always_ff @(posedge clock) begin
		if (rst) begin
			busy <= 1'b0;
			isWrite <= 1'b0;
			count <= '0;
			memFinished <= 1'b0;
			mar <= '0;
			mdr <= '0;
		end else begin
			memFinished <= done;
			if (done) begin
				busy <= 1'b0;
			end else if (startAcc) begin
				busy <= 1'b1;
				isWrite <= write;
			end
			count <= busy ? stepCount : cntW'(1);
			if (marIn)
				mar <= bus;
			// Read data owns MDR until the access ends
			if (done && !curWrite)
				mdr <= mem[curAddr];
			else if (mdrIn && !readActive)
				mdr <= bus;
		end
	end

	always_ff @(posedge clock) begin
		if (startAcc)
			addrReg <= curAddr;
		if (done && curWrite)
			mem[curAddr] <= mdr;
	end

endmodule

`default_nettype wire

//--- verilog/dataPath.sv
`timescale 1ns/100ps
`default_nettype none

module dataPath #(
	parameter int memDepth = 512,
	parameter int memLatency = 3
) (
	input wire clock,
	input wire rst,
	// Bus source enables
	input wire rfOutTb, pcOut, irOut, ryOut, rzLoOut, rzHiOut,
	input wire marOut, hiOut, loOut, immOut, tbOut,
	// Register load enables
	input wire rfInTb, pcIn, irIn, ryIn, rzIn, marIn, hiIn, loIn, incPc,
	input wire dataPathPkg::regIdxT rfSelectTb,
	input wire dataPathPkg::wordT busInTb,
	// ALU control
	input wire dataPathPkg::aluOpT opSelect,
	input wire start,
	output logic finished,
	// Memory control
	input wire read, write, mdrIn, mdrOut,
	output logic memFinished,
	// IR field decode control
	input wire baOut, gra, grb, grc, rOut, rIn,
	output dataPathPkg::wordT busOut
);

	dataPathPkg::wordT bus;
	dataPathPkg::wordT pc, ir, ry, hi, lo;
	dataPathPkg::aluResultT rz, aluResult;
	dataPathPkg::wordT rfData, rzBus, marData, mdrData, immData;
	dataPathPkg::busSelT busSel;

	dataPathPkg::regIdxT selIndex, rfIndex;
	logic selRfIn, selRfOut, selReadZero;
	logic tbRf;

	// Testbench index wins whenever it touches the register file
	assign tbRf = rfInTb | rfOutTb;
	assign rfIndex = tbRf ? rfSelectTb : selIndex;

	regSelect regSelect_i (
		.ir(ir),
		.gra(gra),
		.grb(grb),
		.grc(grc),
		.rIn(rIn),
		.rOut(rOut),
		.baOut(baOut),
		.index(selIndex),
		.rfIn(selRfIn),
		.rfOut(selRfOut),
		.readZero(selReadZero),
		.imm(immData)
	);

	regFile regFile_i (
		.clock(clock),
		.rst(rst),
		.writeEn(rfInTb | selRfIn),
		.index(rfIndex),
		.readZero(selReadZero & ~tbRf),
		.writeData(bus),
		.readData(rfData)
	);

	// Special registers
	always_ff @(posedge clock) begin
		if (rst) begin
			pc <= '0;
			ir <= '0;
			ry <= '0;
			rz <= '0;
			hi <= '0;
			lo <= '0;
		end else begin
			if (incPc)
				pc <= pc + 32'd1;
			else if (pcIn)
				pc <= bus;
			if (irIn)
				ir <= bus;
			if (ryIn)
				ry <= bus;
			if (rzIn)
				rz <= aluResult;
			if (hiIn)
				hi <= bus;
			if (loIn)
				lo <= bus;
		end
	end

	// Low half has priority when both RZ enables are set
	assign rzBus = rzLoOut ? rz.lo : rz.hi;

	assign busSel = '{
		tb: tbOut,
		rf: rfOutTb | selRfOut,
		pc: pcOut,
		ir: irOut,
		ry: ryOut,
		rz: rzLoOut | rzHiOut,
		mar: marOut,
		hi: hiOut,
		lo: loOut,
		mdr: mdrOut,
		imm: immOut
	};

	busMux busMux_i (
		.sel(busSel),
		.tb(busInTb),
		.rf(rfData),
		.pc(pc),
		.ir(ir),
		.ry(ry),
		.rz(rzBus),
		.mar(marData),
		.hi(hi),
		.lo(lo),
		.mdr(mdrData),
		.imm(immData),
		.bus(bus)
	);

	// A comes from RY, B straight off the bus
	alu alu_i (
		.clock(clock),
		.rst(rst),
		.op(opSelect),
		.a(ry),
		.b(bus),
		.start(start),
		.result(aluResult),
		.finished(finished)
	);

	memSys #(
		.memDepth(memDepth),
		.memLatency(memLatency)
	) memSys_i (
		.clock(clock),
		.rst(rst),
		.read(read),
		.write(write),
		.marIn(marIn),
		.mdrIn(mdrIn),
		.bus(bus),
		.mar(marData),
		.mdr(mdrData),
		.memFinished(memFinished)
	);

	assign busOut = bus;

endmodule

`default_nettype wire

//--- test/dataPathTasks.svh
// Xorshift32 stimulus generator
function automatic dataPathPkg::wordT nextRand();
	rngState ^= rngState << 13;
	rngState ^= rngState >> 17;
	rngState ^= rngState << 5;
	return rngState;
endfunction

// Immediate is IR bits 18 to 0 with its sign in bit 18
function automatic dataPathPkg::wordT signExtImm(input dataPathPkg::wordT w);
	if (w[18])
		return {13'h1fff, w[18:0]};
	else
		return {13'h0000, w[18:0]};
endfunction

// Expected hi:lo of an ALU operation
function automatic logic [63:0] aluModel(input dataPathPkg::aluOpT op,
		input dataPathPkg::wordT a, input dataPathPkg::wordT b);
	logic [4:0] s;
	dataPathPkg::wordT r;
	s = b[4:0];
	case (op)
		dataPathPkg::opAdd: r = a + b;
		dataPathPkg::opSub: r = a - b;
		dataPathPkg::opAnd: r = a & b;
		dataPathPkg::opOr: r = a | b;
		dataPathPkg::opShr: r = a >> s;
		dataPathPkg::opShra: r = $signed(a) >>> s;
		dataPathPkg::opShl: r = a << s;
		dataPathPkg::opRor: r = (a >> s) | (a << (6'd32 - s));
		dataPathPkg::opRol: r = (a << s) | (a >> (6'd32 - s));
		// Unary ops take the bus operand
		dataPathPkg::opNeg: r = -b;
		dataPathPkg::opNot: r = ~b;
		dataPathPkg::opMul: return {32'd0, a} * {32'd0, b};
		dataPathPkg::opDiv: return (b == 0) ? {a, 32'hffffffff} : {a % b, a / b};
		default: r = '0;
	endcase
	return {32'd0, r};
endfunction

task automatic clearStrobes();
	{rfOutTb, pcOut, irOut, ryOut, rzLoOut, rzHiOut, marOut, hiOut, loOut} = '0;
	{immOut, tbOut, rfInTb, pcIn, irIn, ryIn, rzIn, marIn, hiIn, loIn} = '0;
	{incPc, start, read, write, mdrIn, mdrOut} = '0;
	{baOut, gra, grb, grc, rOut, rIn} = '0;
	busChk = 1'b0;
endtask

// Strobes last exactly one clock
task automatic step();
	@(negedge clock);
	clearStrobes();
endtask

task automatic expectBus(input dataPathPkg::wordT v);
	expBus = v;
	busChk = 1'b1;
endtask

task automatic putBus(input dataPathPkg::wordT v);
	tbOut = 1'b1;
	busInTb = v;
	expectBus(v);
endtask

// Source numbers follow bus priority
task automatic enableSource(input int k);
	case (k)
		0: tbOut = 1'b1;
		1: begin
			rfOutTb = 1'b1;
			rfSelectTb = 4'd5;
		end
		2: pcOut = 1'b1;
		3: irOut = 1'b1;
		4: ryOut = 1'b1;
		5: rzLoOut = 1'b1;
		6: marOut = 1'b1;
		7: hiOut = 1'b1;
		8: loOut = 1'b1;
		9: mdrOut = 1'b1;
		default: immOut = 1'b1;
	endcase
endtask

task automatic enableLoad(input int k);
	case (k)
		2: pcIn = 1'b1;
		3: irIn = 1'b1;
		4: ryIn = 1'b1;
		6: marIn = 1'b1;
		7: hiIn = 1'b1;
		9: mdrIn = 1'b1;
		default: loIn = 1'b1;
	endcase
endtask

task automatic selectField(input int g);
	gra = (g == 0);
	grb = (g == 1);
	grc = (g == 2);
endtask

task automatic writeReg(input dataPathPkg::regIdxT i, input dataPathPkg::wordT v);
	putBus(v);
	rfInTb = 1'b1;
	rfSelectTb = i;
	step();
	regModel[i] = v;
endtask

// RY gets A and B rides the bus with start before both RZ halves are read
task automatic runAlu(input dataPathPkg::aluOpT op, input dataPathPkg::wordT a,
		input dataPathPkg::wordT b);
	logic [63:0] want;
	want = aluModel(op, a, b);
	putBus(a);
	ryIn = 1'b1;
	step();
	putBus(b);
	opSelect = op;
	start = 1'b1;
	finWin = 1'b1;
	step();
	while (!finished)
		@(negedge clock);
	rzIn = 1'b1;
	step();
	finWin = 1'b0;
	rzLoOut = 1'b1;
	expectBus(want[31:0]);
	step();
	rzHiOut = 1'b1;
	expectBus(want[63:32]);
	step();
endtask

task automatic loadMar(input dataPathPkg::wordT addr);
	putBus(addr);
	marIn = 1'b1;
	step();
endtask

task automatic memAccess(input logic isWrite);
	write = isWrite;
	read = !isWrite;
	memWin = 1'b1;
	step();
	while (!memFinished)
		@(negedge clock);
	step();
	memWin = 1'b0;
endtask

//--- test/dataPathTb.sv
`timescale 1ns/100ps
`default_nettype none

module dataPathTb;

	localparam int memDepth = 512;
	localparam int numTests = 6;
	localparam int memAccesses = 16;

	logic clock = 1'b0;
	logic rst;
	logic rfOutTb, pcOut, irOut, ryOut, rzLoOut, rzHiOut, marOut, hiOut, loOut, immOut, tbOut;
	logic rfInTb, pcIn, irIn, ryIn, rzIn, marIn, hiIn, loIn, incPc;
	logic start, finished, read, write, mdrIn, mdrOut, memFinished;
	logic baOut, gra, grb, grc, rOut, rIn;
	dataPathPkg::regIdxT rfSelectTb;
	dataPathPkg::wordT busInTb, busOut;
	dataPathPkg::aluOpT opSelect;

	// Expectations set by the tasks
	logic busChk, finWin, memWin;
	dataPathPkg::wordT expBus, rngState;
	dataPathPkg::wordT regModel [16];
	dataPathPkg::wordT srcVal [11];
	dataPathPkg::wordT memModel [memDepth];
	int errCount, errMark, passCnt, failCnt;

	`include "dataPathTasks.svh"

	always #10 clock = ~clock;

	dataPath dataPath_i (.*);

	busCheck: assert property (@(posedge clock) disable iff (rst) busChk |-> busOut == expBus)
		else begin
			errCount++;
			$display("CHECK FAILED busOut expected %h got %h", $sampled(expBus), $sampled(busOut));
		end

	// finished and memFinished only inside their wait windows
	finCheck: assert property (@(posedge clock) disable iff (rst) !finWin |-> !finished)
		else begin
			errCount++;
			$display("CHECK FAILED finished expected %h got %h", 1'b0, $sampled(finished));
		end

	memCheck: assert property (@(posedge clock) disable iff (rst) !memWin |-> !memFinished)
		else begin
			errCount++;
			$display("CHECK FAILED memFinished expected %h got %h", 1'b0, $sampled(memFinished));
		end

	task automatic finishTest(input string name);
		if (errCount == errMark) begin
			passCnt++;
			$display("test %s: ok", name);
		end else begin
			failCnt++;
			$display("test %s: %0d errors", name, errCount - errMark);
		end
		errMark = errCount;
	endtask

	task automatic idleAfterReset();
		expectBus('0);
		step();
		for (int k = 1; k < 11; k++) begin
			enableSource(k);
			expectBus('0);
			step();
		end
		rzHiOut = 1'b1;
		expectBus('0);
		step();
	endtask

	task automatic registerTransfers();
		int loadList [7] = '{2, 3, 4, 6, 7, 8, 9};
		for (int i = 0; i < 16; i++)
			writeReg(4'(i), nextRand());
		for (int i = 0; i < 16; i++) begin
			rfOutTb = 1'b1;
			rfSelectTb = 4'(i);
			expectBus(regModel[i]);
			step();
		end
		foreach (loadList[n]) begin
			srcVal[loadList[n]] = nextRand();
			putBus(srcVal[loadList[n]]);
			enableLoad(loadList[n]);
			step();
			enableSource(loadList[n]);
			expectBus(srcVal[loadList[n]]);
			step();
		end
		// incPc wins over pcIn
		putBus(nextRand());
		pcIn = 1'b1;
		incPc = 1'b1;
		step();
		srcVal[2] = srcVal[2] + 1;
		pcOut = 1'b1;
		expectBus(srcVal[2]);
		step();
		srcVal[0] = nextRand();
		srcVal[1] = regModel[5];
		srcVal[10] = signExtImm(srcVal[3]);
		for (int i = 0; i < 10; i++)
			for (int j = i + 1; j < 11; j++) begin
				busInTb = srcVal[0];
				enableSource(i);
				enableSource(j);
				expectBus(srcVal[i]);
				step();
			end
	endtask

	task automatic singleCycleAlu();
		dataPathPkg::aluOpT ops [11];
		ops = '{dataPathPkg::opAdd, dataPathPkg::opSub, dataPathPkg::opAnd, dataPathPkg::opOr,
			dataPathPkg::opShr, dataPathPkg::opShra, dataPathPkg::opShl, dataPathPkg::opRor,
			dataPathPkg::opRol, dataPathPkg::opNeg, dataPathPkg::opNot};
		foreach (ops[n])
			for (int m = 0; m < 4; m++)
				runAlu(ops[n], nextRand(), nextRand());
	endtask

	task automatic multiplyDivide();
		for (int n = 0; n < 6; n++) begin
			runAlu(dataPathPkg::opMul, nextRand(), nextRand());
			runAlu(dataPathPkg::opDiv, nextRand(), nextRand() >> (nextRand() % 32));
		end
		runAlu(dataPathPkg::opMul, '1, '1);
		runAlu(dataPathPkg::opDiv, nextRand(), '0);
	endtask

	task automatic memoryRoundTrip();
		dataPathPkg::wordT addr [8];
		dataPathPkg::wordT v;
		// Most full 32-bit addresses wrap
		foreach (addr[n]) begin
			addr[n] = nextRand();
			v = nextRand();
			loadMar(addr[n]);
			putBus(v);
			mdrIn = 1'b1;
			step();
			memAccess(1'b1);
			memModel[addr[n] % memDepth] = v;
		end
		foreach (addr[n]) begin
			loadMar(addr[n] % memDepth);
			memAccess(1'b0);
			mdrOut = 1'b1;
			expectBus(memModel[addr[n] % memDepth]);
			step();
		end
	endtask

	task automatic irDecode();
		dataPathPkg::regIdxT fld [3];
		dataPathPkg::wordT irVal, v;
		for (int n = 0; n < 4; n++) begin
			fld[0] = (n == 3) ? 4'd0 : 4'(nextRand());
			fld[1] = 4'(nextRand());
			// Bit 18 alternates so both immediate signs occur
			fld[2] = {1'(n), 3'(nextRand())};
			irVal = {5'(nextRand()), fld[0], fld[1], fld[2], 15'(nextRand())};
			putBus(irVal);
			irIn = 1'b1;
			step();
			for (int g = 0; g < 3; g++) begin
				v = nextRand();
				putBus(v);
				selectField(g);
				rIn = 1'b1;
				step();
				regModel[fld[g]] = v;
				selectField(g);
				rOut = 1'b1;
				expectBus(v);
				step();
			end
			// Decoded targets seen through the testbench index
			for (int g = 0; g < 3; g++) begin
				rfOutTb = 1'b1;
				rfSelectTb = fld[g];
				expectBus(regModel[fld[g]]);
				step();
			end
			immOut = 1'b1;
			expectBus(signExtImm(irVal));
			step();
			writeReg(4'd0, nextRand() | 32'd1);
			gra = 1'b1;
			baOut = 1'b1;
			expectBus((fld[0] == 0) ? '0 : regModel[fld[0]]);
			step();
		end
	endtask

	initial begin
		rst = 1'b1;
		rngState = 32'hd8195050;
		busInTb = '0;
		rfSelectTb = '0;
		opSelect = dataPathPkg::opAdd;
		{finWin, memWin, expBus} = '0;
		{errCount, errMark, passCnt, failCnt} = '0;
		srcVal = '{default: '0};
		clearStrobes();
		repeat (2) @(negedge clock);
		rst = 1'b0;
		idleAfterReset();
		finishTest("reset and idle");
		registerTransfers();
		finishTest("register transfers");
		singleCycleAlu();
		finishTest("single-cycle ALU");
		multiplyDivide();
		finishTest("multiply and divide");
		memoryRoundTrip();
		finishTest("memory");
		irDecode();
		finishTest("IR decode");
		$display("%0d tests passed, %0d tests failed", passCnt, failCnt);
		if (failCnt == 0 && errCount == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	// Budget of 200 cycles per test and 40 per memory access
	initial begin
		#((numTests * 200 + memAccesses * 40) * 20);
		$display("Timeout: the tests did not complete in the allowed time");
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
verilog/dataPathPkg.sv
verilog/regFile.sv
verilog/regSelect.sv
verilog/busMux.sv
verilog/alu.sv
verilog/memSys.sv
verilog/dataPath.sv
+incdir+test
test/dataPathTb.sv
